// File: clip_samples.hex
// one 16-bit sample per line, word address 0 first, all words nonzero and distinct
// clip 02 at 0..9, clip 04 at 10..15, clip 06 at 16..23, clip 07 at 24..31
2100 // clip 02
3F40
5A80
6E20
7A10
7FF0
7A12
6E24
5A86
3F48
C104 // clip 04
A214
8324
A234
C144
E054
1106 // clip 06
2216
3326
4436
3346
2256
1166
0876
F107 // clip 07
E217
D327
C437
B547
C657
D767
E877

// File: sound_mux.f
logic/ac97_link_pkg.sv
logic/sound_pkg.sv
logic/frame_counter.sv
logic/codec_init_fsm.sv
logic/frame_serializer.sv
logic/clip_selector.sv
logic/sample_player.sv
logic/clip_rom.sv
logic/sound_mux_top.sv
tests/tb_sound_mux.sv

// File: Bender.yml
package:
  name: sound_mux

sources:
  - logic/ac97_link_pkg.sv
  - logic/sound_pkg.sv
  - logic/frame_counter.sv
  - logic/codec_init_fsm.sv
  - logic/frame_serializer.sv
  - logic/clip_selector.sv
  - logic/sample_player.sv
  - logic/clip_rom.sv
  - logic/sound_mux_top.sv
  - target: test
    files:
      - tests/tb_sound_mux.sv

// File: tests/tb_sound_mux.sv
// testbench for the AC'97 sound player
// link frame capture on the falling clock edge, sound code table, clip order checks
`timescale 1ns/100ps

module tb_sound_mux import ac97_link_pkg::*, sound_pkg::*; ();

  localparam int n_steps = 8;

  logic        ac97_bitclk;
  logic        rst_b;
  sound_code_t sound_sel;
  logic        ac97_sdata_out;
  logic        ac97_sync;
  logic        ac97_reset_b;

  sample_t audio_q [$];           // slot 3 sample of every frame
  sample_t ref_mem [clip_words];  // clip memory image
  int      seed = 89;

  // clip ids 0..3 = clips 02, 04, 06, 07
  int clip_base [4] = '{clip_02_base, clip_04_base, clip_06_base, clip_07_base};
  int clip_last [4] = '{clip_02_last, clip_04_last, clip_06_last, clip_07_last};
  reg_idx_t cmd_reg [6] = '{reg_reset, reg_master_vol, reg_pcm_vol,
                            reg_power, reg_vid0, reg_vid1};

  // code, hold in frames, clip that should follow (-1 silence)
  sound_code_t step_code [n_steps] = '{code_02, code_04, code_06, code_05,
                                       code_0a, 8'h03, code_07, code_02};
  int step_hold [n_steps] = '{24, 16, 10, 16, 14, 14, 10, 8};
  int step_clip [n_steps] = '{0, 1, 2, 1, 3, -1, 3, 0};

  sound_mux_top UUT (
    .ac97_bitclk    (ac97_bitclk),
    .rst_b          (rst_b),
    .sound_sel      (sound_sel),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sync      (ac97_sync),
    .ac97_reset_b   (ac97_reset_b)
  );

  initial begin
    ac97_bitclk = 1'b0;
    forever #5 ac97_bitclk = ~ac97_bitclk;  // 10 ns bit clock
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("at %0t ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopped on timeout");
  endtask

  // memory address of a sample word, -1 for silence, -2 for an unknown word
  function automatic int word_pos(input sample_t w);
    if (w == '0) return -1;
    for (int a = 0; a < clip_words; a++) begin
      if (ref_mem[a] == w) return a;
    end
    return -2;
  endfunction

  function automatic int next_addr(input int c, input int a);
    if (c < 0) return -1;  // silence stays silent
    return (a == clip_base[c] + clip_last[c]) ? clip_base[c] : a + 1;  // wrap at clip end
  endfunction

  function automatic bit in_clip(input int c, input int a);
    if (c < 0) return a == -1;
    return a >= clip_base[c] && a <= clip_base[c] + clip_last[c];
  endfunction

  function automatic int start_addr(input int c);
    return (c < 0) ? -1 : clip_base[c];
  endfunction

  task automatic wait_frames(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = (target - audio_q.size() + 1) * frame_bits;
    while (audio_q.size() < target) begin
      @(posedge ac97_bitclk);
      cycles++;
      if (cycles > limit) give_up("timeout waiting for link frames");
    end
  endtask

  // old clip words in order, then the new sound from its first word
  task automatic check_window(input int first, input int hold, input int prev_c,
                              input int new_c, input bit cut);
    int t;       // frame where the new sound starts
    int a;
    int prev_a;
    int limit;
    t      = -1;
    prev_a = -1;
    for (int i = 0; i < hold; i++) begin
      a = word_pos(audio_q[first + i]);
      if (t < 0 && a == start_addr(new_c)) begin
        t = i;
        if (!cut && prev_c >= 0 && new_c >= 0) begin
          check_val(prev_a, clip_base[prev_c] + clip_last[prev_c],
                    "old clip ran to its last word");
        end
      end else if (i == 0) begin
        check_val(in_clip(prev_c, a), 1'b1, "window opens in the old clip");
      end else begin
        check_val(a, next_addr((t < 0) ? prev_c : new_c, prev_a), "clip word order");
      end
      prev_a = a;
    end
    // a waiting switch may sit through a whole old clip, plus two pipeline frames
    limit = (cut || prev_c < 0) ? 2 : clip_last[prev_c] + 2;
    check_val(t >= 0 && t <= limit, 1'b1, "new sound starts in time");
  endtask

  // sample on the falling edge, as the codec does
  initial begin : frame_monitor
    logic [0:frame_bits-1] fbits;  // bit 0 = first on the wire
    logic [19:0]           s3;
    int                    frame_no;
    int                    cycles;
    int                    j;
    frame_no = 0;
    cycles   = 0;
    @(negedge ac97_bitclk);
    while (rst_b !== 1'b1) begin
      check_val(ac97_reset_b, 1'b0, "codec reset low during reset");
      cycles++;
      if (cycles > 20) give_up("reset was never released");
      @(negedge ac97_bitclk);
    end
    forever begin
      for (int n = 0; n < frame_bits - 1; n++) begin
        fbits[n] = ac97_sdata_out;
        check_val(ac97_sync, n <= sync_last_idx, "sync level");
        check_val(ac97_reset_b, frame_no > 0 || n > 0, "codec reset released");
        @(negedge ac97_bitclk);
      end
      cycles = 0;
      while (ac97_sync !== 1'b1) begin  // next frame is cut where sync rises
        cycles++;
        if (cycles > 8) give_up("sync did not rise at the end of a frame");
        @(negedge ac97_bitclk);
      end
      check_val(cycles, 0, "sync rise position");
      fbits[frame_bits - 1] = ac97_sdata_out;
      j = (frame_no < 3) ? frame_no : 3 + (frame_no - 3) % 3;  // writes, then read loop
      check_val(fbits[0:15], {1'b1, 4'hF, 11'h000}, "tag");
      check_val(fbits[16:35], {j >= 3, cmd_reg[j], 12'h000}, "slot 1 command address");
      check_val(fbits[36:55], {(j == 2) ? pcm_gain_0db : 16'h0000, 4'h0},
                "slot 2 command data");
      s3 = fbits[56:75];
      check_val(fbits[76:95], s3, "slot 4 equals slot 3");
      check_val(s3[3:0], 4'h0, "slot 3 low bits");
      check_val(word_pos(s3[19:4]) != -2, 1'b1, "slot 3 holds silence or a clip word");
      check_val(|fbits[96:frame_bits-1], 1'b0, "slots 5 to 12 zero");
      audio_q.push_back(s3[19:4]);
      frame_no++;
      @(negedge ac97_bitclk);
    end
  end

  initial begin : stimulus
    int n0;
    int prev_c;
    int offset;
    bit cut;
    rst_b     = 1'b0;
    sound_sel = '0;
    prev_c    = -1;  // silent after reset
    $readmemh("clip_samples.hex", ref_mem);
    repeat (3) @(posedge ac97_bitclk);
    #1 rst_b = 1'b1;
    for (int s = 0; s < n_steps; s++) begin
      wait_frames(audio_q.size() + 1);
      offset = $unsigned($random(seed)) % 200;  // selection point within the frame
      repeat (offset) @(posedge ac97_bitclk);
      #1;
      n0        = audio_q.size();  // frame now on the wire
      sound_sel = step_code[s];
      cut = (step_code[s] == code_02) || (step_code[s] == code_06) ||
            (step_code[s] == code_07);
      wait_frames(n0 + step_hold[s]);
      check_window(n0, step_hold[s], prev_c, step_clip[s], cut);
      prev_c = step_clip[s];
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: logic/sound_mux_top.sv
// sound player top level
// AC-link side: bit counter, codec setup, serializer
// sound side: selector, player, clip memory
`timescale 1ns/100ps

module sound_mux_top import sound_pkg::*, ac97_link_pkg::*; (
  input  logic        ac97_bitclk,
  input  logic        rst_b,
  input  sound_code_t sound_sel,
  output logic        ac97_sdata_out,
  output logic        ac97_sync,
  output logic        ac97_reset_b
);

  bit_idx_t   bit_idx;
  logic       frame_load;     // last bit of every frame
  slot_t      cmd_addr_slot;
  slot_t      cmd_data_slot;
  slot_t      audio_slot;
  logic       sound_change;
  logic       clip_finished;
  logic       clip_silent;
  clip_addr_t clip_base;
  clip_addr_t clip_last;
  clip_addr_t rom_addr;
  sample_t    rom_data;

  frame_counter u_frame_counter (
    .ac97_bitclk  (ac97_bitclk),
    .rst_b        (rst_b),
    .bit_idx      (bit_idx),
    .frame_load   (frame_load),
    .ac97_sync    (ac97_sync),
    .ac97_reset_b (ac97_reset_b)
  );

  codec_init_fsm u_codec_init_fsm (
    .ac97_bitclk   (ac97_bitclk),
    .rst_b         (rst_b),
    .frame_load    (frame_load),
    .cmd_addr_slot (cmd_addr_slot),
    .cmd_data_slot (cmd_data_slot)
  );

  frame_serializer u_frame_serializer (
    .bit_idx        (bit_idx),
    .cmd_addr_slot  (cmd_addr_slot),
    .cmd_data_slot  (cmd_data_slot),
    .audio_slot     (audio_slot),
    .ac97_sdata_out (ac97_sdata_out)
  );

  clip_selector u_clip_selector (
    .ac97_bitclk   (ac97_bitclk),
    .rst_b         (rst_b),
    .sound_sel     (sound_sel),
    .clip_finished (clip_finished),
    .sound_change  (sound_change),
    .clip_base     (clip_base),
    .clip_last     (clip_last),
    .clip_silent   (clip_silent)
  );

  sample_player u_sample_player (
    .ac97_bitclk   (ac97_bitclk),
    .rst_b         (rst_b),
    .frame_load    (frame_load),
    .sound_change  (sound_change),
    .clip_base     (clip_base),
    .clip_last     (clip_last),
    .clip_silent   (clip_silent),
    .rom_data      (rom_data),
    .rom_addr      (rom_addr),
    .clip_finished (clip_finished),
    .audio_slot    (audio_slot)
  );

  clip_rom u_clip_rom (
    .ac97_bitclk (ac97_bitclk),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data)
  );

endmodule

// File: logic/clip_rom.sv
// clip sample memory, registered read
// contents from clip_samples.hex
`timescale 1ns/100ps

module clip_rom import sound_pkg::*; (
  input  logic       ac97_bitclk,
  input  clip_addr_t rom_addr,
  output sample_t    rom_data
);

  sample_t mem [clip_words];

  initial begin
    $readmemh("clip_samples.hex", mem);
  end

  // one clock read latency
  always_ff @(posedge ac97_bitclk) begin
    rom_data <= mem[rom_addr];
  end

endmodule

// File: logic/sample_player.sv
// clip sample player
// index walk, memory address issue, hold and current sample registers
// clip end flag and audio slot word
`timescale 1ns/100ps

module sample_player import sound_pkg::*, ac97_link_pkg::*; (
  input  logic       ac97_bitclk,
  input  logic       rst_b,
  input  logic       frame_load,
  input  logic       sound_change,
  input  clip_addr_t clip_base,
  input  clip_addr_t clip_last,
  input  logic       clip_silent,
  input  sample_t    rom_data,
  output clip_addr_t rom_addr,
  output logic       clip_finished,
  output slot_t      audio_slot
);

  clip_addr_t idx;          // position within the clip
  clip_addr_t idx_now;      // index after a pending restart
  logic       addr_silent;  // address was issued during silence
  sample_t    held_sample;  // memory word waiting for next frame
  sample_t    cur_sample;   // word on the link this frame

  // switch restarts at clip start, even on a frame_load cycle
  assign idx_now = sound_change ? '0 : idx;

  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      idx           <= '0;
      rom_addr      <= '0;
      addr_silent   <= 1'b1;
      clip_finished <= 1'b0;
      cur_sample    <= '0;
    end else if (frame_load) begin
      rom_addr    <= clip_base + idx_now;
      addr_silent <= clip_silent;
      cur_sample  <= clip_silent ? '0 : held_sample;
      if (clip_silent || idx_now == clip_last) begin
        idx           <= '0;  // wrap, flag end for one frame
        clip_finished <= 1'b1;
      end else begin
        idx           <= idx_now + clip_addr_t'(1);
        clip_finished <= 1'b0;
      end
    end else if (sound_change) begin
      idx <= '0;
    end
  end

  // memory answers one clock after the address, keep it until frame_load
  always_ff @(posedge ac97_bitclk) begin
    if (!frame_load) begin
      held_sample <= addr_silent ? '0 : rom_data;
    end
  end

  assign audio_slot = {cur_sample, 4'h0};  // 16 bits left-justified in 20

endmodule

// File: logic/clip_selector.sv
// sound code latch and switch decision
// alias table from sound code to clip base and last index
`timescale 1ns/100ps

module clip_selector import sound_pkg::*; (
  input  logic        ac97_bitclk,
  input  logic        rst_b,
  input  sound_code_t sound_sel,
  input  logic        clip_finished,
  output logic        sound_change,
  output clip_addr_t  clip_base,
  output clip_addr_t  clip_last,
  output logic        clip_silent
);

  sound_code_t sel_latched;  // sampled request
  sound_code_t cur_code;     // code now playing
  logic        force_change;
  logic        change_now;

  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      sel_latched <= '0;
    end else begin
      sel_latched <= sound_sel;
    end
  end

  // these codes cut in without waiting for clip end
  always_comb begin
    force_change = 1'b0;
    if (sel_latched != cur_code) begin
      case (sel_latched)
        code_02, code_06, code_07: force_change = 1'b1;
        default:                   force_change = 1'b0;
      endcase
    end
  end

  assign change_now = force_change || clip_finished;

  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      cur_code     <= '0;
      sound_change <= 1'b0;
    end else begin
      sound_change <= change_now && (sel_latched != cur_code);  // only on a real swap
      if (change_now) begin
        cur_code <= sel_latched;
      end
    end
  end

  // alias table
  always_comb begin
    clip_base   = '0;
    clip_last   = '0;
    clip_silent = 1'b0;
    case (cur_code)
      code_02: begin
        clip_base = clip_02_base;
        clip_last = clip_02_last;
      end
      code_04, code_05: begin
        clip_base = clip_04_base;
        clip_last = clip_04_last;
      end
      code_06: begin
        clip_base = clip_06_base;
        clip_last = clip_06_last;
      end
      code_07, code_0a: begin
        clip_base = clip_07_base;
        clip_last = clip_07_last;
      end
      default: clip_silent = 1'b1;  // no clip for this code
    endcase
  end

endmodule

// File: logic/frame_serializer.sv
// AC-link output frame layout
// tag, command slots, audio slots, zero fill and bit select
`timescale 1ns/100ps

module frame_serializer import ac97_link_pkg::*; (
  input  bit_idx_t bit_idx,
  input  slot_t    cmd_addr_slot,
  input  slot_t    cmd_data_slot,
  input  slot_t    audio_slot,
  output logic     ac97_sdata_out
);

  logic [tag_bits-1:0]   tag;
  logic [0:frame_bits-1] frame_vec;  // index 0 goes out first

  // frame valid, slots 1..4 valid, rest of tag zero
  assign tag = {1'b1, 4'b1111, {(tag_bits - 5){1'b0}}};

  assign frame_vec = {
    tag,
    cmd_addr_slot,      // slot 1
    cmd_data_slot,      // slot 2
    audio_slot,         // slot 3 left
    audio_slot,         // slot 4 right, same sample
    {fill_bits{1'b0}}   // slots 5..12 unused
  };

  // straight decode from bit index
  assign ac97_sdata_out = frame_vec[bit_idx];

endmodule

// File: logic/codec_init_fsm.sv
// codec setup FSM
// three register writes, then a loop of status reads
// command address and data words for slots 1 and 2
`timescale 1ns/100ps

module codec_init_fsm import ac97_link_pkg::*; (
  input  logic  ac97_bitclk,
  input  logic  rst_b,
  input  logic  frame_load,
  output slot_t cmd_addr_slot,
  output slot_t cmd_data_slot
);

  codec_state_t state, next_state;
  logic         cmd_read;   // 1 = read, 0 = write
  reg_idx_t     cmd_reg;
  logic [15:0]  cmd_data;

  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      state <= init_reset;
    end else if (frame_load) begin  // one command per frame
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cmd_read   = 1'b1;
    cmd_reg    = reg_power;
    cmd_data   = 16'h0000;  // reads carry no data
    case (state)
      init_reset: begin
        cmd_read   = 1'b0;
        cmd_reg    = reg_reset;  // any write resets the codec
        next_state = init_master;
      end
      init_master: begin
        cmd_read   = 1'b0;
        cmd_reg    = reg_master_vol;  // 0 = unmuted, full level
        next_state = init_pcm;
      end
      init_pcm: begin
        cmd_read   = 1'b0;
        cmd_reg    = reg_pcm_vol;
        cmd_data   = pcm_gain_0db;
        next_state = poll_power;
      end
      poll_power: begin
        cmd_reg    = reg_power;
        next_state = poll_vid0;
      end
      poll_vid0: begin
        cmd_reg    = reg_vid0;
        next_state = poll_vid1;
      end
      poll_vid1: begin
        cmd_reg    = reg_vid1;
        next_state = poll_power;  // keep polling
      end
      default: next_state = init_reset;
    endcase
  end

  // slot 1: r/w, index, 12 reserved; slot 2: data left-justified
  assign cmd_addr_slot = {cmd_read, cmd_reg, 12'h000};
  assign cmd_data_slot = {cmd_data, 4'h0};

endmodule

// File: logic/frame_counter.sv
// free-running AC-link bit counter
// sync and frame-load decode, codec reset release
`timescale 1ns/100ps

module frame_counter import ac97_link_pkg::*; (
  input  logic     ac97_bitclk,
  input  logic     rst_b,
  output bit_idx_t bit_idx,
  output logic     frame_load,
  output logic     ac97_sync,
  output logic     ac97_reset_b
);

  // 8 bits wrap exactly at the frame length
  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      bit_idx <= '0;
    end else begin
      bit_idx <= bit_idx + bit_idx_t'(1);
    end
  end

  assign frame_load = (bit_idx == bit_idx_t'(frame_bits - 1));  // last bit of frame

  // rises during bit 255, falls after the last tag-1 bit
  assign ac97_sync = frame_load || (bit_idx <= sync_last_idx);

  // codec leaves reset one clock after ours
  always_ff @(posedge ac97_bitclk or negedge rst_b) begin
    if (!rst_b) begin
      ac97_reset_b <= 1'b0;
    end else begin
      ac97_reset_b <= 1'b1;
    end
  end

endmodule

// File: logic/sound_pkg.sv
// sound code, sample and clip memory types
// clip table with base address and last index per clip
package sound_pkg;

  typedef logic [7:0]  sound_code_t;
  typedef logic [15:0] sample_t;
  typedef logic [4:0]  clip_addr_t;   // word address into clip memory

  localparam int clip_words = 32;

  // clips sit end to end in the memory
  localparam clip_addr_t clip_02_base = 5'd0;
  localparam clip_addr_t clip_02_last = 5'd9;
  localparam clip_addr_t clip_04_base = 5'd10;
  localparam clip_addr_t clip_04_last = 5'd5;
  localparam clip_addr_t clip_06_base = 5'd16;
  localparam clip_addr_t clip_06_last = 5'd7;
  localparam clip_addr_t clip_07_base = 5'd24;
  localparam clip_addr_t clip_07_last = 5'd7;

  // requested sound codes
  localparam sound_code_t code_02 = 8'h02;
  localparam sound_code_t code_04 = 8'h04;
  localparam sound_code_t code_05 = 8'h05;  // alias of 04
  localparam sound_code_t code_06 = 8'h06;
  localparam sound_code_t code_07 = 8'h07;
  localparam sound_code_t code_0a = 8'h0A;  // alias of 07

endpackage

// File: logic/ac97_link_pkg.sv
// AC-link frame geometry and slot word types
// codec setup FSM states and AC'97 register indices
package ac97_link_pkg;

  typedef logic [7:0]  bit_idx_t;  // bit position within a frame
  typedef logic [19:0] slot_t;     // one slot word, MSB first on the wire
  typedef logic [6:0]  reg_idx_t;  // codec register index

  // frame layout
  localparam int frame_bits = 256;
  localparam int tag_bits   = 16;
  localparam int slot_bits  = 20;
  localparam int fill_bits  = frame_bits - tag_bits - 4 * slot_bits; // slots 5..12

  // sync covers bit 255 and the tag up to here
  localparam bit_idx_t sync_last_idx = 8'd14;

  // codec setup sequence
  typedef enum logic [2:0] {
    init_reset,
    init_master,
    init_pcm,
    poll_power,
    poll_vid0,
    poll_vid1
  } codec_state_t;

  localparam reg_idx_t reg_reset      = 7'h00;
  localparam reg_idx_t reg_master_vol = 7'h02;
  localparam reg_idx_t reg_pcm_vol    = 7'h18;
  localparam reg_idx_t reg_power      = 7'h26;  // powerdown ctrl/status
  localparam reg_idx_t reg_vid0       = 7'h7C;
  localparam reg_idx_t reg_vid1       = 7'h7E;

  localparam logic [15:0] pcm_gain_0db = 16'h0808;  // unmuted, both channels 0 dB

endpackage
